//--- Bender.yml
package:
  name: memStage

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/memStagePkg.sv
      - verilog/memStageReg.sv
      - verilog/storeAlign.sv
      - verilog/dataMem.sv
      - verilog/cp0Regs.sv
      - verilog/exceptionUnit.sv
      - verilog/memStageTop.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/memStageTb.sv

//--- tests/memStageTb.sv
// directed testbench for the memory stage with RAM model, CP0 checks and watchdog
`timescale 1ns/100ps
`default_nettype none

`include "memStage_params.svh"

module memStageTb;
    import memStagePkg::*;

    localparam int rounds = 16;
    localparam int testCycles = 8 + rounds * 21 + 120; // reset, load/store rounds, the rest

    logic        clk;
    logic        arstN;
    logic        memFlush;
    logic        memWr;
    logic        memDisWr;
    logic [5:0]  interrupt;
    logic [31:0] exAluOut;
    logic [31:0] exStoreData;
    logic [31:0] exPc;
    loadType_e   exLoadType;
    storeType_e  exStoreType;
    logic [4:0]  exDst;
    logic        exRegWr;
    cp0Op_e      exCp0Op;
    logic [4:0]  exCp0Addr;
    excCode_e    exExcCode;
    logic        exInDelaySlot;
    logic [31:0] memPc;
    logic [4:0]  memDst;
    logic        memRegWr;
    logic [31:0] memResult;
    logic [31:0] loadData;
    logic        flushException;
    logic [31:0] exceptionVector;
    logic [31:0] cp0Epc;

    int          errors;
    int          checks;
    int unsigned seedValue;
    logic [31:0] nextPc;
    logic [31:0] lastPc;                 // pc of the most recent op
    logic [31:0] lastBase;               // a word known to the model
    logic [31:0] model [`DMEM_WORDS];

    memStageTop memStageTop_inst (
        .clk, .arstN, .memFlush, .memWr, .memDisWr, .interrupt,
        .exAluOut, .exStoreData, .exPc, .exLoadType, .exStoreType, .exDst,
        .exRegWr, .exCp0Op, .exCp0Addr, .exExcCode, .exInDelaySlot,
        .memPc, .memDst, .memRegWr, .memResult, .loadData,
        .flushException, .exceptionVector, .cp0Epc
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic checkWord(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic checkExc(input string name, input excCode_e expected, input excCode_e actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic checkDst(input string name, input logic [4:0] expected,
                            input logic [4:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // expected load result straight from the model bytes
    function automatic logic [31:0] expectLoad(input loadType_e kind, input logic [31:0] addr);
        logic [31:0] word;
        logic [7:0]  b;
        logic [15:0] h;
        word = model[(addr >> 2) % `DMEM_WORDS];
        b = word[addr[1:0]*8 +: 8];
        h = word[addr[1]*16 +: 16];
        case (kind)
            LD_LB:   return {{24{b[7]}}, b};
            LD_LBU:  return {24'd0, b};
            LD_LH:   return {{16{h[15]}}, h};
            LD_LHU:  return {16'd0, h};
            default: return word;
        endcase
    endfunction

    task automatic storeModel(input storeType_e st, input logic [31:0] addr,
                              input logic [31:0] data);
        int idx;
        idx = (addr >> 2) % `DMEM_WORDS;
        case (st)
            ST_SB:   model[idx][addr[1:0]*8 +: 8] = data[7:0];
            ST_SH:   model[idx][addr[1]*16 +: 16] = data[15:0];
            ST_SW:   model[idx] = data;
            default: ;
        endcase
    endtask

    // one op for one cycle, then a bubble; returns mid-cycle while the op is in MEM
    task automatic issueOp(input logic [31:0] aluOut, input logic [31:0] storeData,
                           input loadType_e ld, input storeType_e st, input cp0Op_e cop,
                           input logic [4:0] cpAddr, input excCode_e exc, input logic inSlot,
                           input logic disWr, input logic flush);
        @(posedge clk);
        lastPc = nextPc;
        nextPc = nextPc + 32'd4;
        exPc          <= lastPc;
        exAluOut      <= aluOut;
        exStoreData   <= storeData;
        exLoadType    <= ld;
        exStoreType   <= st;
        exCp0Op       <= cop;
        exCp0Addr     <= cpAddr;
        exExcCode     <= exc;
        exInDelaySlot <= inSlot;
        exDst         <= lastPc[6:2]; // differs from op to op
        exRegWr       <= 1'b1; // always on so the gating shows
        memFlush      <= flush;
        memDisWr      <= 1'b0;
        @(posedge clk);
        exPc          <= 32'd0;
        exLoadType    <= LD_NONE;
        exStoreType   <= ST_NONE;
        exCp0Op       <= CP0_NONE;
        exExcCode     <= EXC_NONE;
        exInDelaySlot <= 1'b0;
        exRegWr       <= 1'b0;
        memFlush      <= 1'b0;
        memDisWr      <= disWr; // stall level during the MEM cycle
        @(negedge clk);
    endtask

    task automatic doStore(input storeType_e st, input logic [31:0] addr,
                           input logic [31:0] data, input logic disWr, input logic flush);
        issueOp(addr, data, LD_NONE, st, CP0_NONE, 5'd0, EXC_NONE, 1'b0, disWr, flush);
    endtask

    task automatic doLoad(input string name, input loadType_e ld, input logic [31:0] addr);
        issueOp(addr, 32'd0, ld, ST_NONE, CP0_NONE, 5'd0, EXC_NONE, 1'b0, 1'b0, 1'b0);
        checkBit({name, " regWr"}, 1'b1, memRegWr);
        checkWord({name, " pc"}, lastPc, memPc);
        checkDst({name, " dst"}, lastPc[6:2], memDst);
        @(posedge clk); // read cycle
        @(negedge clk);
        checkWord(name, expectLoad(ld, addr), loadData);
    endtask

    task automatic readCp0(input logic [4:0] addr, output logic [31:0] value);
        issueOp(32'd0, 32'd0, LD_NONE, ST_NONE, CP0_MFC0, addr, EXC_NONE, 1'b0, 1'b0, 1'b0);
        value = memResult;
    endtask

    task automatic writeCp0(input logic [4:0] addr, input logic [31:0] data);
        issueOp(32'd0, data, LD_NONE, ST_NONE, CP0_MTC0, addr, EXC_NONE, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic resetTest();
        logic [31:0] value;
        checkBit("reset flush", 1'b0, flushException);
        checkBit("reset regWr", 1'b0, memRegWr);
        readCp0(`CP0_STATUS, value);
        checkWord("reset status", `STATUS_RESET, value);
        readCp0(`CP0_CAUSE, value);
        checkExc("reset cause", EXC_INT, excCode_e'(value[6:2]));
    endtask

    task automatic loadStoreTest();
        logic [31:0] base;
        logic [31:0] addr;
        logic [31:0] data;
        for (int r = 0; r < rounds; r++) begin
            base = ($urandom % `DMEM_WORDS) * 4;
            data = $urandom;
            doStore(ST_SW, base, data, 1'b0, 1'b0);
            storeModel(ST_SW, base, data);
            addr = base + ($urandom % 2) * 2;
            data = $urandom;
            doStore(ST_SH, addr, data, 1'b0, 1'b0);
            storeModel(ST_SH, addr, data);
            addr = base + ($urandom % 4);
            data = $urandom;
            doStore(ST_SB, addr, data, 1'b0, 1'b0);
            storeModel(ST_SB, addr, data);
            doLoad("lw", LD_LW, base);
            doLoad("lh", LD_LH, base + ($urandom % 2) * 2);
            doLoad("lhu", LD_LHU, base + ($urandom % 2) * 2);
            doLoad("lb", LD_LB, base + ($urandom % 4));
            doLoad("lbu", LD_LBU, base + ($urandom % 4));
        end
        lastBase = base;
    endtask

    task automatic addressErrorTest();
        logic [31:0] value;
        logic [31:0] badPc;
        issueOp(lastBase + 1, 32'd0, LD_LH, ST_NONE, CP0_NONE, 5'd0, EXC_NONE, 1'b0, 1'b0, 1'b0);
        badPc = lastPc;
        checkBit("adel lh flush", 1'b1, flushException);
        checkWord("adel lh vector", `BOOT_EXC_VECTOR, exceptionVector);
        checkBit("adel lh regWr", 1'b0, memRegWr);
        @(posedge clk);
        @(negedge clk);
        checkWord("adel lh epc", badPc, cp0Epc);
        readCp0(`CP0_BADVADDR, value);
        checkWord("adel lh badvaddr", lastBase + 1, value);
        readCp0(`CP0_CAUSE, value);
        checkExc("adel lh cause", EXC_ADEL, excCode_e'(value[6:2]));
        issueOp(lastBase + 2, 32'd0, LD_LW, ST_NONE, CP0_NONE, 5'd0, EXC_NONE, 1'b0, 1'b0, 1'b0);
        checkBit("adel lw flush", 1'b1, flushException);
        checkWord("adel lw vector", `BOOT_EXC_VECTOR, exceptionVector);
        doStore(ST_SW, lastBase + 3, $urandom, 1'b0, 1'b0);
        badPc = lastPc;
        checkBit("ades sw flush", 1'b1, flushException);
        checkWord("ades sw vector", `BOOT_EXC_VECTOR, exceptionVector);
        @(posedge clk);
        @(negedge clk);
        checkWord("ades sw epc", badPc, cp0Epc);
        readCp0(`CP0_BADVADDR, value);
        checkWord("ades sw badvaddr", lastBase + 3, value);
        readCp0(`CP0_CAUSE, value);
        checkExc("ades sw cause", EXC_ADES, excCode_e'(value[6:2]));
        doLoad("ades memory", LD_LW, lastBase); // faulting store must not land
    endtask

    task automatic interruptTest();
        logic [31:0] value;
        logic [31:0] intPc;
        writeCp0(`CP0_STATUS, 32'h0000_0401); // IE and IM2, BEV clear
        @(posedge clk);
        interrupt <= 6'b000001;               // shows up as IP2
        issueOp(32'h10, 32'd0, LD_NONE, ST_NONE, CP0_NONE, 5'd0, EXC_NONE, 1'b0, 1'b0, 1'b0);
        intPc = lastPc;
        checkBit("int flush", 1'b1, flushException);
        checkWord("int vector", `EXC_VECTOR, exceptionVector);
        @(posedge clk);
        interrupt <= 6'b000000;
        @(negedge clk);
        checkWord("int epc", intPc, cp0Epc);
        readCp0(`CP0_CAUSE, value);
        checkExc("int cause", EXC_INT, excCode_e'(value[6:2]));
        readCp0(`CP0_STATUS, value);
        checkBit("int exl", 1'b1, value[`STATUS_EXL]);
        issueOp(32'd0, 32'd0, LD_NONE, ST_NONE, CP0_ERET, 5'd0, EXC_NONE, 1'b0, 1'b0, 1'b0);
        checkBit("eret flush", 1'b1, flushException);
        checkWord("eret vector", intPc, exceptionVector);
        readCp0(`CP0_STATUS, value);
        checkBit("eret exl", 1'b0, value[`STATUS_EXL]);
    endtask

    task automatic delaySlotTest();
        logic [31:0] value;
        logic [31:0] slotPc;
        issueOp(32'd0, 32'd0, LD_NONE, ST_NONE, CP0_NONE, 5'd0, EXC_SYS, 1'b1, 1'b0, 1'b0);
        slotPc = lastPc;
        checkBit("slot flush", 1'b1, flushException);
        checkWord("slot vector", `EXC_VECTOR, exceptionVector);
        @(posedge clk);
        @(negedge clk);
        checkWord("slot epc", slotPc - 32'd4, cp0Epc); // epc names the branch
        readCp0(`CP0_CAUSE, value);
        checkBit("slot bd", 1'b1, value[`CAUSE_BD]);
        checkExc("slot cause", EXC_SYS, excCode_e'(value[6:2]));
    endtask

    task automatic suppressionTest();
        doStore(ST_SW, lastBase, $urandom, 1'b1, 1'b0);
        checkBit("stall regWr", 1'b0, memRegWr);
        doLoad("stall memory", LD_LW, lastBase);
        doStore(ST_SW, lastBase, $urandom, 1'b0, 1'b1);
        checkBit("flushed regWr", 1'b0, memRegWr);
        doLoad("flushed memory", LD_LW, lastBase);
    endtask

    initial begin
        seedValue = $urandom(32'h40cd);
        errors = 0;
        checks = 0;
        nextPc = 32'h0040_0000;
        lastPc = 32'd0;
        lastBase = 32'd0;
        arstN = 1'b0;
        memWr = 1'b0;
        memFlush = 1'b0;
        memDisWr = 1'b0;
        interrupt = 6'd0;
        exAluOut = 32'd0;
        exStoreData = 32'd0;
        exPc = 32'd0;
        exLoadType = LD_NONE;
        exStoreType = ST_NONE;
        exDst = 5'd0;
        exRegWr = 1'b0;
        exCp0Op = CP0_NONE;
        exCp0Addr = 5'd0;
        exExcCode = EXC_NONE;
        exInDelaySlot = 1'b0;
        repeat (8) @(posedge clk);
        arstN <= 1'b1;
        memWr <= 1'b1;
        @(negedge clk);
        resetTest();
        loadStoreTest();
        addressErrorTest();
        interruptTest();
        delaySlotTest();
        suppressionTest();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // watchdog, twice the expected run length
    initial begin
        #(testCycles * 2 * 4);
        $display("Watchdog expired before the tests finished");
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/cp0Regs.sv
// coprocessor 0 registers Status, Cause, EPC and BadVAddr with exception and ERET updates
`timescale 1ns/100ps
`default_nettype none

`include "memStage_params.svh"

module cp0Regs (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic [5:0]            interrupt,
    input  logic                  wrEn,
    input  logic [4:0]            wrAddr,
    input  logic [4:0]            rdAddr,
    input  logic [31:0]           wrData,
    input  logic                  excTaken,
    input  memStagePkg::excCode_e  excCode,
    input  logic                  isEret,
    input  logic [31:0]           excPc,
    input  logic                  excInDelaySlot,
    input  logic [31:0]           badAddr,
    output logic [31:0]           rdData,
    output logic                  statusBev,
    output logic                  statusExl,
    output logic                  statusIe,
    output logic [7:0]            statusIm,
    output logic [7:0]            causeIp,
    output logic [31:0]           epc
);
    import memStagePkg::*;

    // software-visible Status bits: BEV, IM7..0, EXL, IE
    localparam logic [31:0] statusWrMask = (32'h1 << `STATUS_BEV) | 32'h0000_FF00 |
                                           (32'h1 << `STATUS_EXL) | (32'h1 << `STATUS_IE);

    logic [31:0] statusReg;
    logic        causeBd;
    logic [5:0]  ipHw;
    logic [1:0]  ipSw;
    logic [4:0]  causeExc;
    logic [31:0] causeRead;
    logic [31:0] badVAddr;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            statusReg <= `STATUS_RESET;
            causeBd   <= 1'b0;
            ipHw      <= '0;
            ipSw      <= '0;
            causeExc  <= '0;
        end else begin
            ipHw <= interrupt; // IP7..2 track the pins
            if (wrEn && wrAddr == `CP0_STATUS) begin
                statusReg <= wrData & statusWrMask;
            end
            if (wrEn && wrAddr == `CP0_CAUSE) begin
                ipSw <= wrData[9:8];
            end
            if (excTaken) begin
                statusReg[`STATUS_EXL] <= 1'b1;
                causeExc               <= excCode;
                causeBd                <= excInDelaySlot;
            end else if (isEret) begin
                statusReg[`STATUS_EXL] <= 1'b0;
            end
        end
    end

    // epc and bad address are plain data
    always_ff @(posedge clk) begin
        if (excTaken) begin
            epc <= excInDelaySlot ? excPc - 32'd4 : excPc; // point at the branch
            if (excCode == EXC_ADEL || excCode == EXC_ADES) begin
                badVAddr <= badAddr;
            end
        end else if (wrEn && wrAddr == `CP0_EPC) begin
            epc <= wrData;
        end
    end

    assign statusBev = statusReg[`STATUS_BEV];
    assign statusExl = statusReg[`STATUS_EXL];
    assign statusIe  = statusReg[`STATUS_IE];
    assign statusIm  = statusReg[15:8];
    assign causeIp   = {ipHw, ipSw};

    always_comb begin
        causeRead            = '0;
        causeRead[`CAUSE_BD] = causeBd;
        causeRead[15:8]      = causeIp;
        causeRead[6:2]       = causeExc;
    end

    always_comb begin
        case (rdAddr)
            `CP0_STATUS:   rdData = statusReg;
            `CP0_CAUSE:    rdData = causeRead;
            `CP0_EPC:      rdData = epc;
            `CP0_BADVADDR: rdData = badVAddr;
            default:       rdData = '0;
        endcase
    end

    // exception entry always wins over ERET upstream
    entryNotEret: assert property (@(posedge clk) disable iff (!arstN)
        !(excTaken && isEret));

endmodule

`default_nettype wire

//--- verilog/dataMem.sv
// synchronous byte-writable data RAM with registered load extraction and extension
`timescale 1ns/100ps
`default_nettype none

`include "memStage_params.svh"

module dataMem (
    input  logic                             clk,
    input  logic                             arstN,
    input  logic                             wrEn,
    input  logic [3:0]                       byteEn,
    input  logic [$clog2(`DMEM_WORDS)-1:0]   wordAddr,
    input  logic [31:0]                      wrData,
    input  memStagePkg::loadType_e            loadType,
    input  logic [1:0]                       addrLow,
    output logic [31:0]                      loadData
);
    import memStagePkg::*;

    logic [31:0] mem [`DMEM_WORDS];
    logic [31:0] rdWord;
    loadType_e   rdType;
    logic [1:0]  rdOff;
    logic [7:0]  rdByte;
    logic [15:0] rdHalf;

    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (wrEn && byteEn[lane]) begin
                mem[wordAddr][lane*8 +: 8] <= wrData[lane*8 +: 8];
            end
        end
        if (loadType != LD_NONE) begin
            rdWord <= mem[wordAddr];
        end
    end

    // kind and offset of the last load, held until the next one
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rdType <= LD_NONE;
            rdOff  <= 2'b00;
        end else if (loadType != LD_NONE) begin
            rdType <= loadType;
            rdOff  <= addrLow;
        end
    end

    assign rdByte = rdWord[{rdOff, 3'b000} +: 8];
    assign rdHalf = rdOff[1] ? rdWord[31:16] : rdWord[15:0];

    always_comb begin
        case (rdType)
            LD_LB:   loadData = {{24{rdByte[7]}}, rdByte};
            LD_LBU:  loadData = {24'b0, rdByte};
            LD_LH:   loadData = {{16{rdHalf[15]}}, rdHalf};
            LD_LHU:  loadData = {16'b0, rdHalf};
            LD_LW:   loadData = rdWord;
            default: loadData = '0; // nothing loaded since reset
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/exceptionUnit.sv
// exception prioritisation with interrupt detection, flush and handler vector selection
`timescale 1ns/100ps
`default_nettype none

`include "memStage_params.svh"

module exceptionUnit (
    input  logic [31:0]            memPc,
    input  memStagePkg::excCode_e   excCodeIn,
    input  memStagePkg::cp0Op_e     cp0Op,
    input  memStagePkg::loadType_e  loadType,
    input  memStagePkg::storeType_e storeType,
    input  logic                   misaligned,
    input  logic                   statusBev,
    input  logic                   statusExl,
    input  logic                   statusIe,
    input  logic [7:0]             statusIm,
    input  logic [7:0]             causeIp,
    input  logic [31:0]            epc,
    output logic                   excTaken,
    output memStagePkg::excCode_e   excCode,
    output logic                   isEret,
    output logic                   flushException,
    output logic [31:0]            exceptionVector
);
    import memStagePkg::*;

    logic isBubble;
    logic intPending;

    // a bubble carries pc 0 and no work
    assign isBubble = (memPc == '0) && (loadType == LD_NONE) && (storeType == ST_NONE) &&
                      (cp0Op == CP0_NONE) && (excCodeIn == EXC_NONE);
    assign intPending = statusIe && !statusExl && |(statusIm & causeIp);

    always_comb begin
        excCode = EXC_NONE;
        if (!isBubble) begin
            if (intPending) begin
                excCode = EXC_INT;
            end else if (excCodeIn != EXC_NONE) begin
                excCode = excCodeIn; // raised in an earlier stage
            end else if (misaligned && loadType != LD_NONE) begin
                excCode = EXC_ADEL;
            end else if (misaligned && storeType != ST_NONE) begin
                excCode = EXC_ADES;
            end
        end
    end

    // any cause at all, independent of which one wins
    assign excTaken       = !isBubble && (intPending || (excCodeIn != EXC_NONE) ||
                            (misaligned && (loadType != LD_NONE || storeType != ST_NONE)));
    assign isEret         = (cp0Op == CP0_ERET) && !excTaken;
    assign flushException = excTaken || isEret;

    always_comb begin
        if (isEret) begin
            exceptionVector = epc;
        end else if (statusBev) begin
            exceptionVector = `BOOT_EXC_VECTOR;
        end else begin
            exceptionVector = `EXC_VECTOR;
        end
    end

    always_comb begin
        noCodeWithoutExc: assert final (excTaken || excCode == EXC_NONE);
    end

endmodule

`default_nettype wire

//--- verilog/memStagePkg.sv
// memory stage package holding the load, store, CP0 operation and exception code types
`default_nettype none

package memStagePkg;

    // load kind carried down the pipe
    typedef enum logic [2:0] {
        LD_NONE,
        LD_LB,
        LD_LBU,
        LD_LH,
        LD_LHU,
        LD_LW
    } loadType_e;

    typedef enum logic [1:0] {
        ST_NONE,
        ST_SB,
        ST_SH,
        ST_SW
    } storeType_e;

    // coprocessor 0 operation
    typedef enum logic [1:0] {
        CP0_NONE,
        CP0_MFC0,
        CP0_MTC0,
        CP0_ERET
    } cp0Op_e;

    // Cause.ExcCode values, EXC_NONE is not architectural
    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_SYS  = 5'd8,
        EXC_BP   = 5'd9,
        EXC_RI   = 5'd10,
        EXC_OV   = 5'd12,
        EXC_NONE = 5'd31
    } excCode_e;

endpackage

`default_nettype wire

//--- verilog/memStageReg.sv
// execute-to-memory pipeline register with hold on stall and bubble on flush
`timescale 1ns/100ps
`default_nettype none

module memStageReg (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   memFlush,
    input  logic                   memWr,
    input  logic [31:0]            exAluOut,
    input  logic [31:0]            exStoreData,
    input  logic [31:0]            exPc,
    input  memStagePkg::loadType_e  exLoadType,
    input  memStagePkg::storeType_e exStoreType,
    input  logic [4:0]             exDst,
    input  logic                   exRegWr,
    input  memStagePkg::cp0Op_e     exCp0Op,
    input  logic [4:0]             exCp0Addr,
    input  memStagePkg::excCode_e   exExcCode,
    input  logic                   exInDelaySlot,
    output logic [31:0]            memAluOut,
    output logic [31:0]            memStoreData,
    output logic [31:0]            memPc,
    output memStagePkg::loadType_e  memLoadType,
    output memStagePkg::storeType_e memStoreType,
    output logic [4:0]             memDst,
    output logic                   memRegWrRaw,
    output memStagePkg::cp0Op_e     memCp0Op,
    output logic [4:0]             memCp0Addr,
    output memStagePkg::excCode_e   memExcCodeIn,
    output logic                   memInDelaySlot
);
    import memStagePkg::*;

    // control fields, a bubble has pc 0 and no side effects
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN || memFlush) begin
            memPc          <= '0;
            memLoadType    <= LD_NONE;
            memStoreType   <= ST_NONE;
            memRegWrRaw    <= 1'b0;
            memCp0Op       <= CP0_NONE;
            memExcCodeIn   <= EXC_NONE;
            memInDelaySlot <= 1'b0;
        end else if (memWr) begin
            memPc          <= exPc;
            memLoadType    <= exLoadType;
            memStoreType   <= exStoreType;
            memRegWrRaw    <= exRegWr;
            memCp0Op       <= exCp0Op;
            memExcCodeIn   <= exExcCode;
            memInDelaySlot <= exInDelaySlot;
        end
    end

    // data fields only follow a capture
    always_ff @(posedge clk) begin
        if (memWr && !memFlush) begin
            memAluOut    <= exAluOut;
            memStoreData <= exStoreData;
            memDst       <= exDst;
            memCp0Addr   <= exCp0Addr;
        end
    end

    // a flushed slot keeps its store killed until something new is captured
    flushHoldsBubble: assert property (@(posedge clk) disable iff (!arstN)
        memFlush |=> (memStoreType == ST_NONE) until_with (memWr || memFlush));

endmodule

`default_nettype wire

//--- verilog/memStageTop.sv
// memory stage top connecting stage register, store aligner, RAM, CP0 and exception unit
`timescale 1ns/100ps
`default_nettype none

`include "memStage_params.svh"

module memStageTop (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   memFlush,
    input  logic                   memWr,
    input  logic                   memDisWr,
    input  logic [5:0]             interrupt,
    input  logic [31:0]            exAluOut,
    input  logic [31:0]            exStoreData,
    input  logic [31:0]            exPc,
    input  memStagePkg::loadType_e  exLoadType,
    input  memStagePkg::storeType_e exStoreType,
    input  logic [4:0]             exDst,
    input  logic                   exRegWr,
    input  memStagePkg::cp0Op_e     exCp0Op,
    input  logic [4:0]             exCp0Addr,
    input  memStagePkg::excCode_e   exExcCode,
    input  logic                   exInDelaySlot,
    output logic [31:0]            memPc,
    output logic [4:0]             memDst,
    output logic                   memRegWr,
    output logic [31:0]            memResult,
    output logic [31:0]            loadData,
    output logic                   flushException,
    output logic [31:0]            exceptionVector,
    output logic [31:0]            cp0Epc
);
    import memStagePkg::*;

    localparam int wordBits = $clog2(`DMEM_WORDS);

    logic [31:0] memAluOut;
    logic [31:0] memStoreData;
    loadType_e   memLoadType;
    storeType_e  memStoreType;
    logic        memRegWrRaw;
    cp0Op_e      memCp0Op;
    logic [4:0]  memCp0Addr;
    excCode_e    memExcCodeIn;
    logic        memInDelaySlot;
    logic [3:0]  byteEn;
    logic [31:0] wrData;
    logic        misaligned;
    logic        excTaken;
    excCode_e    excCode;
    logic        isEret;
    logic        statusBev;
    logic        statusExl;
    logic        statusIe;
    logic [7:0]  statusIm;
    logic [7:0]  causeIp;
    logic [31:0] cp0RdData;
    logic        commitOk;

    // side effects only when not stalled and not faulting
    assign commitOk  = !memDisWr && !excTaken;
    assign memRegWr  = memRegWrRaw && commitOk;
    assign memResult = (memCp0Op == CP0_MFC0) ? cp0RdData : memAluOut;

    memStageReg memStageReg_inst (
        .clk, .arstN, .memFlush, .memWr,
        .exAluOut, .exStoreData, .exPc, .exLoadType, .exStoreType, .exDst,
        .exRegWr, .exCp0Op, .exCp0Addr, .exExcCode, .exInDelaySlot,
        .memAluOut, .memStoreData, .memPc, .memLoadType, .memStoreType, .memDst,
        .memRegWrRaw, .memCp0Op, .memCp0Addr, .memExcCodeIn, .memInDelaySlot
    );

    storeAlign storeAlign_inst (
        .addrLow   (memAluOut[1:0]),
        .loadType  (memLoadType),
        .storeType (memStoreType),
        .storeData (memStoreData),
        .byteEn, .wrData, .misaligned
    );

    dataMem dataMem_inst (
        .clk, .arstN,
        .wrEn     ((memStoreType != ST_NONE) && commitOk),
        .byteEn,
        .wordAddr (memAluOut[wordBits+1:2]),
        .wrData,
        .loadType (memLoadType),
        .addrLow  (memAluOut[1:0]),
        .loadData
    );

    cp0Regs cp0Regs_inst (
        .clk, .arstN, .interrupt,
        .wrEn           ((memCp0Op == CP0_MTC0) && commitOk),
        .wrAddr         (memCp0Addr),
        .rdAddr         (memCp0Addr),
        .wrData         (memStoreData),
        .excTaken       (excTaken && !memDisWr), // stalled entry repeats later
        .excCode,
        .isEret         (isEret && !memDisWr),
        .excPc          (memPc),
        .excInDelaySlot (memInDelaySlot),
        .badAddr        (memAluOut),
        .rdData         (cp0RdData),
        .statusBev, .statusExl, .statusIe, .statusIm, .causeIp,
        .epc            (cp0Epc)
    );

    exceptionUnit exceptionUnit_inst (
        .memPc,
        .excCodeIn (memExcCodeIn),
        .cp0Op     (memCp0Op),
        .loadType  (memLoadType),
        .storeType (memStoreType),
        .misaligned,
        .statusBev, .statusExl, .statusIe, .statusIm, .causeIp,
        .epc       (cp0Epc),
        .excTaken, .excCode, .isEret, .flushException, .exceptionVector
    );

endmodule

`default_nettype wire

//--- verilog/memStage_params.svh
// memory stage constants for CP0 register numbers, status/cause bits, vectors and RAM depth
`ifndef MEMSTAGE_PARAMS_SVH
`define MEMSTAGE_PARAMS_SVH

// cp0 register numbers, select 0 only
`define CP0_BADVADDR 5'd8
`define CP0_STATUS 5'd12
`define CP0_CAUSE 5'd13
`define CP0_EPC 5'd14

// status and cause bit positions
`define STATUS_BEV 22
`define STATUS_EXL 1
`define STATUS_IE 0
`define CAUSE_BD 31

`define STATUS_RESET 32'h0040_0000 // boot vectors selected

// handler entry points
`define BOOT_EXC_VECTOR 32'hBFC0_0380
`define EXC_VECTOR 32'h8000_0180

`define DMEM_WORDS 256 // data RAM depth in words

`endif

//--- verilog/storeAlign.sv
// store lane formation with byte enables, plus load and store alignment checks
`timescale 1ns/100ps
`default_nettype none

module storeAlign (
    input  logic [1:0]             addrLow,
    input  memStagePkg::loadType_e  loadType,
    input  memStagePkg::storeType_e storeType,
    input  logic [31:0]            storeData,
    output logic [3:0]             byteEn,
    output logic [31:0]            wrData,
    output logic                   misaligned
);
    import memStagePkg::*;

    logic halfAccess;
    logic wordAccess;

    assign halfAccess = (loadType == LD_LH) || (loadType == LD_LHU) || (storeType == ST_SH);
    assign wordAccess = (loadType == LD_LW) || (storeType == ST_SW);
    assign misaligned = (halfAccess && addrLow[0]) || (wordAccess && (addrLow != 2'b00));

    always_comb begin
        byteEn = 4'b0000;
        wrData = storeData;
        case (storeType)
            ST_SB: begin
                wrData = {4{storeData[7:0]}}; // same byte on every lane
                byteEn = 4'b0001 << addrLow;
            end
            ST_SH: begin
                wrData = {2{storeData[15:0]}};
                byteEn = addrLow[1] ? 4'b1100 : 4'b0011;
            end
            ST_SW: byteEn = 4'b1111;
            default: byteEn = 4'b0000;
        endcase
        if (misaligned) begin
            byteEn = 4'b0000; // faulting store touches no lane
        end
    end

    // no lane may be enabled unless a store is aligned
    always_comb begin
        laneOnlyForStore: assert final ((byteEn == 4'b0000) ||
                                        (storeType != ST_NONE && !misaligned));
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+verilog
verilog/memStagePkg.sv
verilog/memStageReg.sv
verilog/storeAlign.sv
verilog/dataMem.sv
verilog/cp0Regs.sv
verilog/exceptionUnit.sv
verilog/memStageTop.sv
tests/memStageTb.sv
